//--- colorMapper_stim.txt
# name kind drawX drawY ballX ballY ballSize sprite hunger happiness red green blue eaten hurt foodIndex
# sprite and colour columns in hex, all others decimal
bgLeft pixel 0 0 1000 1000 1 00 50 50 00 ff a0 0 0 0
bgMid pixel 200 400 1000 1000 1 00 50 50 00 e6 b9 0 0 0
bgWrap pixel 800 10 1000 1000 1 00 50 50 00 9b 04 0 0 0
ballCentre pixel 220 400 220 400 10 00 50 50 00 00 00 0 0 0
ballEdge pixel 230 400 220 400 10 00 50 50 00 00 00 0 0 0
ballEdgeDiag pixel 226 408 220 400 10 00 50 50 00 00 00 0 0 0
ballOutside pixel 231 400 220 400 10 00 50 50 00 e3 bc 0 0 0
ballOutDiag pixel 227 408 220 400 10 00 50 50 00 e3 bc 0 0 0
ballOverPet pixel 123 204 120 200 5 00 50 50 00 00 00 0 0 0
ballNearPet pixel 124 204 120 200 5 00 50 50 ff ff 00 0 0 0
foodPlain pixel 350 70 1000 1000 1 00 50 50 ff 00 ff 0 0 0
foodOverBall pixel 360 80 360 80 20 00 50 50 ff 00 ff 0 0 0
foodCornerTl pixel 340 60 1000 1000 1 00 50 50 ff 00 ff 0 0 0
foodEdgeBr pixel 400 110 1000 1000 1 00 50 50 00 cd d2 0 0 0
petCorner pixel 100 187 1000 1000 1 03 50 50 00 ff 00 0 0 0
petCell pixel 117 203 1000 1000 1 07 50 50 40 00 80 0 0 0
petWrap pixel 148 239 1000 1000 1 fe 50 50 80 80 80 0 0 0
petRightEdge pixel 149 200 1000 1000 1 03 50 50 00 ed b2 0 0 0
hungerFill pixel 90 260 1000 1000 1 00 30 50 00 c0 00 0 0 0
hungerEmpty pixel 105 260 1000 1000 1 00 30 50 40 40 40 0 0 0
hungerClip pixel 133 260 1000 1000 1 00 100 50 00 c0 00 0 0 0
hungerZero pixel 75 250 1000 1000 1 00 0 50 40 40 40 0 0 0
happyFill pixel 130 310 1000 1000 1 00 50 80 ff ff 00 0 0 0
happyEmpty pixel 85 323 1000 1000 1 00 50 10 40 40 40 0 0 0
frameMiss frame 0 0 200 300 0 00 50 50 00 00 00 0 0 0
frameEat0 frame 0 0 350 70 0 00 50 50 00 00 00 1 0 1
foodNext pixel 460 130 1000 1000 1 00 50 50 ff 00 ff 0 0 1
foodOldGone pixel 350 70 1000 1000 1 00 50 50 00 d4 cb 0 0 1
frameHurt frame 0 0 520 150 0 00 0 50 00 00 00 0 1 1
frameEat1 frame 0 0 450 120 0 00 0 50 00 00 00 1 1 2
frameEat2 frame 0 0 589 99 0 00 20 50 00 00 00 1 0 3
frameEat3 frame 0 0 400 150 0 00 50 50 00 00 00 1 0 0

//--- colorMapper.f
displayPkg.sv
gamePkg.sv
foodTable.sv
objectLayer.sv
petLayer.sv
pixelMixer.sv
colorMapper.sv
tbChecker.sv
tbColorMapper.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tbColorMapper
LOG ?= sim.log
FILELIST ?= colorMapper.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the log holds the pass line
run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Test completed successfully$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tbColorMapper.sv
module tbColorMapper
    import displayPkg::*, gamePkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // Per test budget, longer than the checker's own wait
    localparam int stepLimit = 40;

    // DUT ports
    logic                      frame_clk;
    logic                      rstN;
    logic                      pixelValid;
    logic                      frameStart;
    logic [coordWidth-1:0]     drawX;
    logic [coordWidth-1:0]     drawY;
    logic [coordWidth-1:0]     ballX;
    logic [coordWidth-1:0]     ballY;
    logic [ballSizeWidth-1:0]  ballSize;
    logic [7:0]                sprite;
    logic [statWidth-1:0]      hunger;
    logic [statWidth-1:0]      happiness;
    logic [colorWidth-1:0]     red;
    logic [colorWidth-1:0]     green;
    logic [colorWidth-1:0]     blue;
    logic                      rgbValid;
    logic                      eaten;
    logic                      hurt;
    logic [foodIndexWidth-1:0] foodIndex;

    // Expected values on their way to the checker
    logic                      expStrobe;
    logic                      expFrame;
    logic [8*20-1:0]           expName;
    logic [rgbWidth-1:0]       expRgb;
    logic                      expEaten;
    logic                      expHurt;
    logic [foodIndexWidth-1:0] expIndex;
    int                        doneCount;
    int                        failCount;

    // One stimulus line
    logic [8*20-1:0]  nameBits;
    logic [8*8-1:0]   kindBits;
    logic [8*200-1:0] restBits;
    logic [7:0]       lineSprite;
    logic [7:0]       lineRed;
    logic [7:0]       lineGreen;
    logic [7:0]       lineBlue;
    int               lineDrawX;
    int               lineDrawY;
    int               lineBallX;
    int               lineBallY;
    int               lineBallSize;
    int               lineHunger;
    int               lineHappy;
    int               lineEaten;
    int               lineHurt;
    int               lineIndex;

    // Run control
    int fd;
    int code;
    int testCount;
    bit aborted;
    bit finished;

    colorMapper i_colorMapper (
        .frame_clk (frame_clk),
        .rstN      (rstN),
        .pixelValid(pixelValid),
        .frameStart(frameStart),
        .drawX     (drawX),
        .drawY     (drawY),
        .ballX     (ballX),
        .ballY     (ballY),
        .ballSize  (ballSize),
        .sprite    (sprite),
        .hunger    (hunger),
        .happiness (happiness),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .rgbValid  (rgbValid),
        .eaten     (eaten),
        .hurt      (hurt),
        .foodIndex (foodIndex)
    );

    tbChecker i_tbChecker (
        .frame_clk (frame_clk),
        .frameStart(frameStart),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .rgbValid  (rgbValid),
        .eaten     (eaten),
        .hurt      (hurt),
        .foodIndex (foodIndex),
        .expStrobe (expStrobe),
        .expFrame  (expFrame),
        .expName   (expName),
        .expRgb    (expRgb),
        .expEaten  (expEaten),
        .expHurt   (expHurt),
        .expIndex  (expIndex),
        .doneCount (doneCount),
        .failCount (failCount)
    );

    // 100 ns clock
    always #50 frame_clk = ~frame_clk;

    // --------------------
    // Drive one test
    // --------------------
    task automatic driveTest(input logic isFrame);
        @(posedge frame_clk);
        pixelValid <= !isFrame;
        frameStart <= isFrame;
        drawX <= lineDrawX[coordWidth-1:0];
        drawY <= lineDrawY[coordWidth-1:0];
        ballX <= lineBallX[coordWidth-1:0];
        ballY <= lineBallY[coordWidth-1:0];
        ballSize <= lineBallSize[ballSizeWidth-1:0];
        sprite <= lineSprite;
        hunger <= lineHunger[statWidth-1:0];
        happiness <= lineHappy[statWidth-1:0];
        // Expectation travels alongside the stimulus
        expStrobe <= 1'b1;
        expFrame <= isFrame;
        expName <= nameBits;
        expRgb <= {lineRed, lineGreen, lineBlue};
        expEaten <= lineEaten[0];
        expHurt <= lineHurt[0];
        expIndex <= lineIndex[foodIndexWidth-1:0];
        @(posedge frame_clk);
        pixelValid <= 1'b0;
        frameStart <= 1'b0;
        expStrobe <= 1'b0;
    endtask

    task automatic awaitVerdict(output bit gotIt);
        int waited;
        waited = 0;
        while (doneCount < testCount && waited < stepLimit)
        begin
            @(posedge frame_clk);
            waited++;
        end
        gotIt = (doneCount >= testCount);
    endtask

    initial
    begin
        bit gotIt;
        frame_clk = 1'b0;
        rstN = 1'b0;
        pixelValid = 1'b0;
        frameStart = 1'b0;
        drawX = '0;
        drawY = '0;
        ballX = '0;
        ballY = '0;
        ballSize = '0;
        sprite = '0;
        hunger = '0;
        happiness = '0;
        expStrobe = 1'b0;
        expFrame = 1'b0;
        expName = '0;
        expRgb = '0;
        expEaten = 1'b0;
        expHurt = 1'b0;
        expIndex = '0;
        testCount = 0;
        aborted = 1'b0;
        finished = 1'b0;

        repeat (8) @(posedge frame_clk);
        rstN <= 1'b1;

        fd = $fopen("colorMapper_stim.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file colorMapper_stim.txt");
            aborted = 1'b1;
        end
        else
        begin
            while (!finished)
            begin
                code = $fscanf(fd, "%s", nameBits);
                if (code != 1)
                    finished = 1'b1;
                else if (nameBits == "#")
                    code = $fgets(restBits, fd);
                else
                begin
                    code = $fscanf(fd, "%s %d %d %d %d %d %h %d %d %h %h %h %d %d %d",
                                   kindBits, lineDrawX, lineDrawY, lineBallX, lineBallY,
                                   lineBallSize, lineSprite, lineHunger, lineHappy,
                                   lineRed, lineGreen, lineBlue, lineEaten, lineHurt,
                                   lineIndex);
                    if (code != 15)
                    begin
                        $display("Stimulus line for %0s is incomplete", string'(nameBits));
                        aborted = 1'b1;
                        finished = 1'b1;
                    end
                    else
                    begin
                        testCount++;
                        driveTest(kindBits == "frame");
                        awaitVerdict(gotIt);
                        if (!gotIt)
                        begin
                            $display("No verdict for %0s within %0d cycles",
                                     string'(nameBits), stepLimit);
                            aborted = 1'b1;
                            finished = 1'b1;
                        end
                    end
                end
            end
            $fclose(fd);
        end

        $display("Tests run %0d, failed %0d, passed %0d",
                 doneCount, failCount, doneCount - failCount);
        if (!aborted && testCount > 0 && failCount == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- tbChecker.sv
module tbChecker
    import displayPkg::*, gamePkg::*;
(
    input  logic                      frame_clk,
    input  logic                      frameStart,
    input  logic [colorWidth-1:0]     red,
    input  logic [colorWidth-1:0]     green,
    input  logic [colorWidth-1:0]     blue,
    input  logic                      rgbValid,
    input  logic                      eaten,
    input  logic                      hurt,
    input  logic [foodIndexWidth-1:0] foodIndex,
    input  logic                      expStrobe,
    input  logic                      expFrame,
    input  logic [8*20-1:0]           expName,
    input  logic [rgbWidth-1:0]       expRgb,
    input  logic                      expEaten,
    input  logic                      expHurt,
    input  logic [foodIndexWidth-1:0] expIndex,
    output int                        doneCount,
    output int                        failCount
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int waitLimit = 20;
    localparam int entryWidth = 1 + 8*20 + rgbWidth + 2 + foodIndexWidth;

    // Pending expectations, oldest first
    logic [entryWidth-1:0] expQ [$];
    // frameStart as the DUT saw it on the last edge
    logic frameSeen = 1'b0;

    // --------------------
    // Expectation intake
    // --------------------
    always @(posedge frame_clk)
    begin
        frameSeen <= frameStart;
        if (expStrobe)
            expQ.push_back({expFrame, expName, expRgb, expEaten, expHurt, expIndex});
    end

    task automatic checkPixel(input string name, input logic [rgbWidth-1:0] want);
        logic [rgbWidth-1:0] got;
        got = {red, green, blue};
        if (got !== want)
        begin
            $display("Error %0s: expected rgb %06h, actual %06h", name, want, got);
            failCount++;
        end
        else
            $display("Passed %0s: rgb %06h", name, got);
    endtask

    task automatic checkFrame(input string name, input logic [foodIndexWidth+1:0] want);
        logic [foodIndexWidth+1:0] got;
        // Packed as eaten, hurt, then the food index
        got = {eaten, hurt, foodIndex};
        if (got !== want)
        begin
            $display("Error %0s: expected eaten %0b hurt %0b index %0d, actual %0b %0b %0d",
                     name, want[foodIndexWidth+1], want[foodIndexWidth],
                     want[foodIndexWidth-1:0], eaten, hurt, foodIndex);
            failCount++;
        end
        else
            $display("Passed %0s: eaten %0b hurt %0b foodIndex %0d",
                     name, eaten, hurt, foodIndex);
    endtask

    task automatic reportMissing(input string name, input string what);
        $display("%0s: the %0s never arrived within %0d cycles", name, what, waitLimit);
        failCount++;
    endtask

    // --------------------
    // Compare loop
    // --------------------
    initial
    begin
        logic                      isFrame;
        logic [8*20-1:0]           nameBits;
        logic [rgbWidth-1:0]       wantRgb;
        logic                      wantEaten;
        logic                      wantHurt;
        logic [foodIndexWidth-1:0] wantIndex;
        int                        waited;
        doneCount = 0;
        failCount = 0;
        forever
        begin
            @(negedge frame_clk);
            if (expQ.size() != 0)
            begin
                {isFrame, nameBits, wantRgb, wantEaten, wantHurt, wantIndex} = expQ.pop_front();
                waited = 0;
                if (isFrame)
                begin
                    // Pulses show up one cycle after frameStart
                    while (!frameSeen && waited < waitLimit)
                    begin
                        @(negedge frame_clk);
                        waited++;
                    end
                    if (!frameSeen)
                        reportMissing(string'(nameBits), "frame pulse window");
                    else
                        checkFrame(string'(nameBits), {wantEaten, wantHurt, wantIndex});
                end
                else
                begin
                    while (!rgbValid && waited < waitLimit)
                    begin
                        @(negedge frame_clk);
                        waited++;
                    end
                    // Entry is queued one cycle after the pixel was driven
                    if (!rgbValid)
                        reportMissing(string'(nameBits), "colour output");
                    else if (waited + 1 != mapperLatency)
                    begin
                        $display("%0s: colour output came after %0d cycles instead of %0d",
                                 string'(nameBits), waited + 1, mapperLatency);
                        failCount++;
                    end
                    else
                        checkPixel(string'(nameBits), wantRgb);
                end
                doneCount++;
            end
        end
    end

endmodule

//--- colorMapper.sv
module colorMapper
    import displayPkg::*, gamePkg::*;
(
    input  logic                      frame_clk,
    input  logic                      rstN,
    input  logic                      pixelValid,
    input  logic                      frameStart,
    input  logic [coordWidth-1:0]     drawX,
    input  logic [coordWidth-1:0]     drawY,
    input  logic [coordWidth-1:0]     ballX,
    input  logic [coordWidth-1:0]     ballY,
    input  logic [ballSizeWidth-1:0]  ballSize,
    input  logic [7:0]                sprite,
    input  logic [statWidth-1:0]      hunger,
    input  logic [statWidth-1:0]      happiness,
    output logic [colorWidth-1:0]     red,
    output logic [colorWidth-1:0]     green,
    output logic [colorWidth-1:0]     blue,
    output logic                      rgbValid,
    output logic                      eaten,
    output logic                      hurt,
    output logic [foodIndexWidth-1:0] foodIndex
);

    // Pet side, two cycles behind the scan
    logic                  petOn;
    logic [rgbWidth-1:0]   petColor;
    logic                  petValid;
    logic [coordWidth-1:0] petDrawX;
    // Object side, same depth
    logic                  ballOn;
    logic                  foodOn;
    logic                  objValid;

    petLayer i_petLayer (
        .frame_clk (frame_clk),
        .rstN      (rstN),
        .pixelValid(pixelValid),
        .drawX     (drawX),
        .drawY     (drawY),
        .sprite    (sprite),
        .hunger    (hunger),
        .happiness (happiness),
        .petOn     (petOn),
        .petColor  (petColor),
        .petValid  (petValid),
        .petDrawX  (petDrawX)
    );

    objectLayer i_objectLayer (
        .frame_clk (frame_clk),
        .rstN      (rstN),
        .pixelValid(pixelValid),
        .frameStart(frameStart),
        .drawX     (drawX),
        .drawY     (drawY),
        .ballX     (ballX),
        .ballY     (ballY),
        .ballSize  (ballSize),
        .hunger    (hunger),
        .ballOn    (ballOn),
        .foodOn    (foodOn),
        .objValid  (objValid),
        .foodIndex (foodIndex),
        .eaten     (eaten),
        .hurt      (hurt)
    );

    pixelMixer i_pixelMixer (
        .frame_clk(frame_clk),
        .rstN     (rstN),
        .petValid (petValid),
        .petOn    (petOn),
        .petColor (petColor),
        .petDrawX (petDrawX),
        .ballOn   (ballOn),
        .foodOn   (foodOn),
        .objValid (objValid),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .rgbValid (rgbValid)
    );

endmodule

//--- pixelMixer.sv
module pixelMixer
    import displayPkg::*;
(
    input  logic                  frame_clk,
    input  logic                  rstN,
    input  logic                  petValid,
    input  logic                  petOn,
    input  logic [rgbWidth-1:0]   petColor,
    input  logic [coordWidth-1:0] petDrawX,
    input  logic                  ballOn,
    input  logic                  foodOn,
    input  logic                  objValid,
    output logic [colorWidth-1:0] red,
    output logic [colorWidth-1:0] green,
    output logic [colorWidth-1:0] blue,
    output logic                  rgbValid
);

    logic [coordWidth-1:0] xStep;
    logic [colorWidth-1:0] bgGreen;
    logic [colorWidth-1:0] bgBlue;
    logic [rgbWidth-1:0]   mixColor;

    // --------------------
    // Priority select
    // --------------------
    always_comb
    begin
        // Gradient, green fades while blue rises
        xStep = petDrawX / bgStep;
        bgGreen = bgGreenBase - xStep[colorWidth-1:0];
        bgBlue = bgBlueBase + xStep[colorWidth-1:0];

        // Food on top, then ball, then pet and bars
        if (foodOn)
            mixColor = foodColor;
        else if (ballOn)
            mixColor = ballColor;
        else if (petOn)
            mixColor = petColor;
        else
            mixColor = {{colorWidth{1'b0}}, bgGreen, bgBlue};
    end

    always_ff @(posedge frame_clk)
    begin
        if (!rstN)
        begin
            rgbValid <= 1'b0;
            red <= '0;
            green <= '0;
            blue <= '0;
        end
        else
        begin
            rgbValid <= petValid;
            if (petValid)
                {red, green, blue} <= mixColor;
        end
    end

    // Both layers must stay in lockstep
    assert property (@(posedge frame_clk) disable iff (!rstN) petValid == objValid);

endmodule

//--- petLayer.sv
module petLayer
    import displayPkg::*, gamePkg::*;
(
    input  logic                  frame_clk,
    input  logic                  rstN,
    input  logic                  pixelValid,
    input  logic [coordWidth-1:0] drawX,
    input  logic [coordWidth-1:0] drawY,
    input  logic [7:0]            sprite,
    input  logic [statWidth-1:0]  hunger,
    input  logic [statWidth-1:0]  happiness,
    output logic                  petOn,
    output logic [rgbWidth-1:0]   petColor,
    output logic                  petValid,
    output logic [coordWidth-1:0] petDrawX
);

    // Stage 1 decode
    logic                   inPet;
    logic                   inHunger;
    logic                   inHappy;
    logic [coordWidth-1:0]  petOffX;
    logic [coordWidth-1:0]  petOffY;
    logic [palIdxWidth-1:0] cellX;
    logic [palIdxWidth-1:0] cellY;
    logic [coordWidth-1:0]  barOff;
    logic [coordWidth-1:0]  hungerClip;
    logic [coordWidth-1:0]  happyClip;
    logic [coordWidth-1:0]  barStat;
    logic [regionWidth-1:0] region;
    logic [palIdxWidth-1:0] palIdx;
    logic                   barFill;

    // Stage 1 registers
    logic                   s1Valid;
    logic [regionWidth-1:0] s1Region;
    logic [palIdxWidth-1:0] s1PalIdx;
    logic                   s1Fill;
    logic [coordWidth-1:0]  s1DrawX;

    // Stage 2 lookup
    logic                   s2On;
    logic [rgbWidth-1:0]    s2Color;

    // --------------------
    // Stage 1
    // --------------------
    always_comb
    begin
        inPet = (drawX >= petLeft) && (drawX < petRight)
             && (drawY >= petTop) && (drawY < petBottom);
        inHunger = (drawX >= barLeft) && (drawX < barRight)
                && (drawY >= barHungerTop) && (drawY < barHungerBottom);
        inHappy = (drawX >= barLeft) && (drawX < barRight)
               && (drawY >= barHappyTop) && (drawY < barHappyBottom);

        // Cell coordinates, only the low bits reach the palette
        petOffX = drawX - petLeft;
        petOffY = drawY - petTop;
        cellX = palIdxWidth'(petOffX / cellSize);
        cellY = palIdxWidth'(petOffY / cellSize);
        // 4-bit wrap is the modulo 16
        palIdx = sprite[palIdxWidth-1:0] + cellX + cellY;

        // Stats above the bar length draw as full
        hungerClip = {{(coordWidth-statWidth){1'b0}}, hunger};
        if (hungerClip > barLength)
            hungerClip = barLength;
        happyClip = {{(coordWidth-statWidth){1'b0}}, happiness};
        if (happyClip > barLength)
            happyClip = barLength;

        barOff = drawX - barLeft;
        barStat = inHunger ? hungerClip : happyClip;
        barFill = barOff < barStat;

        // Regions never overlap, order is only a tiebreak
        if (inPet)
            region = regionPet;
        else if (inHunger)
            region = regionHunger;
        else if (inHappy)
            region = regionHappy;
        else
            region = regionNone;
    end

    always_ff @(posedge frame_clk)
    begin
        if (!rstN)
            s1Valid <= 1'b0;
        else
            s1Valid <= pixelValid;
    end

    always_ff @(posedge frame_clk)
    begin
        if (pixelValid)
        begin
            s1Region <= region;
            s1PalIdx <= palIdx;
            s1Fill <= barFill;
            s1DrawX <= drawX;
        end
    end

    // --------------------
    // Stage 2
    // --------------------
    always_comb
    begin
        s2On = 1'b1;
        case (s1Region)
            regionPet:    s2Color = palette[s1PalIdx];
            regionHunger: s2Color = s1Fill ? barHungerColor : barEmptyColor;
            regionHappy:  s2Color = s1Fill ? barHappyColor : barEmptyColor;
            default:
            begin
                s2On = 1'b0;
                s2Color = '0;
            end
        endcase
    end

    always_ff @(posedge frame_clk)
    begin
        if (!rstN)
            petValid <= 1'b0;
        else
            petValid <= s1Valid;
    end

    always_ff @(posedge frame_clk)
    begin
        if (s1Valid)
        begin
            petOn <= s2On;
            petColor <= s2Color;
            // Mixer needs drawX aligned with the colour
            petDrawX <= s1DrawX;
        end
    end

endmodule

//--- objectLayer.sv
module objectLayer
    import displayPkg::*, gamePkg::*;
(
    input  logic                      frame_clk,
    input  logic                      rstN,
    input  logic                      pixelValid,
    input  logic                      frameStart,
    input  logic [coordWidth-1:0]     drawX,
    input  logic [coordWidth-1:0]     drawY,
    input  logic [coordWidth-1:0]     ballX,
    input  logic [coordWidth-1:0]     ballY,
    input  logic [ballSizeWidth-1:0]  ballSize,
    input  logic [statWidth-1:0]      hunger,
    output logic                      ballOn,
    output logic                      foodOn,
    output logic                      objValid,
    output logic [foodIndexWidth-1:0] foodIndex,
    output logic                      eaten,
    output logic                      hurt
);

    // Current food box
    logic [coordWidth-1:0] foodTlX;
    logic [coordWidth-1:0] foodTlY;
    logic [coordWidth-1:0] foodBrX;
    logic [coordWidth-1:0] foodBrY;

    // Stage 1, one extra bit for the sign
    logic signed [coordWidth:0]  distX;
    logic signed [coordWidth:0]  distY;
    logic                        inFood;
    logic                        s1Valid;
    logic signed [coordWidth:0]  s1DistX;
    logic signed [coordWidth:0]  s1DistY;
    logic [ballSizeWidth-1:0]    s1Size;
    logic                        s1Food;

    // Stage 2, squares are never negative
    logic [2*coordWidth+1:0]     distSq;
    logic [2*ballSizeWidth-1:0]  sizeSq;

    foodTable i_foodTable (
        .frame_clk (frame_clk),
        .rstN      (rstN),
        .frameStart(frameStart),
        .ballX     (ballX),
        .ballY     (ballY),
        .hunger    (hunger),
        .foodTlX   (foodTlX),
        .foodTlY   (foodTlY),
        .foodBrX   (foodBrX),
        .foodBrY   (foodBrY),
        .foodIndex (foodIndex),
        .eaten     (eaten),
        .hurt      (hurt)
    );

    // --------------------
    // Stage 1
    // --------------------
    assign distX = $signed({1'b0, drawX}) - $signed({1'b0, ballX});
    assign distY = $signed({1'b0, drawY}) - $signed({1'b0, ballY});
    assign inFood = (drawX >= foodTlX) && (drawX < foodBrX)
                 && (drawY >= foodTlY) && (drawY < foodBrY);

    always_ff @(posedge frame_clk)
    begin
        if (!rstN)
            s1Valid <= 1'b0;
        else
            s1Valid <= pixelValid;
    end

    always_ff @(posedge frame_clk)
    begin
        if (pixelValid)
        begin
            s1DistX <= distX;
            s1DistY <= distY;
            s1Size <= ballSize;
            s1Food <= inFood;
        end
    end

    // --------------------
    // Stage 2
    // --------------------
    // Multipliers get a full cycle here
    assign distSq = s1DistX * s1DistX + s1DistY * s1DistY;
    assign sizeSq = s1Size * s1Size;

    always_ff @(posedge frame_clk)
    begin
        if (!rstN)
            objValid <= 1'b0;
        else
            objValid <= s1Valid;
    end

    always_ff @(posedge frame_clk)
    begin
        if (s1Valid)
        begin
            // Edge of the circle counts as inside
            ballOn <= distSq <= {{(2*coordWidth+2-2*ballSizeWidth){1'b0}}, sizeSq};
            foodOn <= s1Food;
        end
    end

endmodule

//--- foodTable.sv
module foodTable
    import displayPkg::*, gamePkg::*;
(
    input  logic                      frame_clk,
    input  logic                      rstN,
    input  logic                      frameStart,
    input  logic [coordWidth-1:0]     ballX,
    input  logic [coordWidth-1:0]     ballY,
    input  logic [statWidth-1:0]      hunger,
    output logic [coordWidth-1:0]     foodTlX,
    output logic [coordWidth-1:0]     foodTlY,
    output logic [coordWidth-1:0]     foodBrX,
    output logic [coordWidth-1:0]     foodBrY,
    output logic [foodIndexWidth-1:0] foodIndex,
    output logic                      eaten,
    output logic                      hurt
);

    logic [foodBoxWidth-1:0] box;
    logic                    ballInBox;
    logic                    lastEntry;

    // Current box, fields packed tlX first
    assign box = foodBoxes[foodIndex];
    assign foodTlX = box[4*coordWidth-1 -: coordWidth];
    assign foodTlY = box[3*coordWidth-1 -: coordWidth];
    assign foodBrX = box[2*coordWidth-1 -: coordWidth];
    assign foodBrY = box[coordWidth-1 -: coordWidth];

    // Ball centre only, radius ignored
    assign ballInBox = (ballX >= foodTlX) && (ballX < foodBrX)
                    && (ballY >= foodTlY) && (ballY < foodBrY);
    assign lastEntry = (foodIndex == foodIndexWidth'(foodCount - 1));

    // --------------------
    // Frame start events
    // --------------------
    always_ff @(posedge frame_clk)
    begin
        if (!rstN)
        begin
            foodIndex <= '0;
            eaten <= 1'b0;
            hurt <= 1'b0;
        end
        else
        begin
            eaten <= frameStart && ballInBox;
            hurt <= frameStart && (hunger == '0);
            // Next food appears once this one is eaten
            if (frameStart && ballInBox)
            begin
                if (lastEntry)
                    foodIndex <= '0;
                else
                    foodIndex <= foodIndex + 1'b1;
            end
        end
    end

    // Pulses stay single even across back-to-back frames
    assert property (@(posedge frame_clk) disable iff (!rstN) eaten |=> !eaten);
    assert property (@(posedge frame_clk) disable iff (!rstN) hurt |=> !hurt);

endmodule

//--- gamePkg.sv
package gamePkg;

    import displayPkg::coordWidth;

    // --------------------
    // Food table
    // --------------------
    localparam int foodCount = 4;
    localparam int foodIndexWidth = 2;
    // One box per word: {tlX, tlY, brX, brY}
    localparam int foodBoxWidth = 4 * coordWidth;

    // Top-left inclusive, bottom-right exclusive
    // All boxes sit in the upper right play field
    localparam logic [foodBoxWidth-1:0] foodBoxes [foodCount] = '{
        {10'd340, 10'd60, 10'd400, 10'd110},
        {10'd450, 10'd120, 10'd520, 10'd180},
        {10'd540, 10'd50, 10'd590, 10'd100},
        {10'd380, 10'd140, 10'd440, 10'd190}
    };

    // --------------------
    // Pet stats and ball
    // --------------------
    // Hunger and happiness, 0 to 100
    localparam int statWidth = 7;

    // Ball radius in pixels, up to 63
    localparam int ballSizeWidth = 6;

endpackage

//--- displayPkg.sv
package displayPkg;

    // --------------------
    // Screen geometry
    // --------------------
    localparam int coordWidth = 10;
    localparam int colorWidth = 8;
    // Packed {red, green, blue}
    localparam int rgbWidth = 3 * colorWidth;

    // Pet sprite box, left and top inclusive
    localparam logic [coordWidth-1:0] petLeft = 10'd100;
    localparam logic [coordWidth-1:0] petRight = 10'd149;
    localparam logic [coordWidth-1:0] petTop = 10'd187;
    localparam logic [coordWidth-1:0] petBottom = 10'd240;
    // Sprite cell edge in pixels
    localparam logic [coordWidth-1:0] cellSize = 10'd8;

    // Status bars share the same columns
    localparam logic [coordWidth-1:0] barLeft = 10'd75;
    localparam logic [coordWidth-1:0] barRight = 10'd134;
    localparam logic [coordWidth-1:0] barHungerTop = 10'd250;
    localparam logic [coordWidth-1:0] barHungerBottom = 10'd274;
    localparam logic [coordWidth-1:0] barHappyTop = 10'd300;
    localparam logic [coordWidth-1:0] barHappyBottom = 10'd324;
    // Longest drawable fill, stats clip here
    localparam logic [coordWidth-1:0] barLength = 10'd59;

    // Region codes for the pet layer
    localparam int regionWidth = 2;
    localparam logic [regionWidth-1:0] regionNone = 2'd0;
    localparam logic [regionWidth-1:0] regionPet = 2'd1;
    localparam logic [regionWidth-1:0] regionHunger = 2'd2;
    localparam logic [regionWidth-1:0] regionHappy = 2'd3;

    // --------------------
    // Colours
    // --------------------
    localparam int palIdxWidth = 4;
    // Fixed sprite palette, entry 0 first
    localparam logic [rgbWidth-1:0] palette [2**palIdxWidth] = '{
        24'h000000, 24'hffffff, 24'hff0000, 24'h00ff00,
        24'h0000ff, 24'hffff00, 24'h00ffff, 24'hff8000,
        24'h804000, 24'hffc0c0, 24'h808080, 24'h400080,
        24'h008040, 24'hc0c0ff, 24'hff4080, 24'h206020
    };
    localparam logic [rgbWidth-1:0] barHungerColor = 24'h00c000;
    localparam logic [rgbWidth-1:0] barHappyColor = 24'hffff00;
    localparam logic [rgbWidth-1:0] barEmptyColor = 24'h404040;
    localparam logic [rgbWidth-1:0] foodColor = 24'hff00ff;
    localparam logic [rgbWidth-1:0] ballColor = 24'h000000;

    // Gradient steps once per 8 columns
    localparam logic [coordWidth-1:0] bgStep = 10'd8;
    localparam logic [colorWidth-1:0] bgGreenBase = 8'hff;
    localparam logic [colorWidth-1:0] bgBlueBase = 8'ha0;

    // Pipeline depth, layers then mixer
    localparam int layerLatency = 2;
    localparam int mapperLatency = 3;

endpackage
